// File: mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// first fetch address out of reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// primary opcodes, instruction[31:26]
`define OP_SPECIAL 6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111

// regimm rt codes, instruction[20:16]
`define RT_BLTZ    5'b00000
`define RT_BGEZ    5'b00001
`define RT_BLTZAL  5'b10000
`define RT_BGEZAL  5'b10001

// special function codes, instruction[5:0]
`define FN_JR      6'b001000
`define FN_JALR    6'b001001

// default link destination
`define LINK_REG   5'd31

`endif

// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

    // data word moved between registers
    typedef logic [31:0] word_t;

    // byte address on the fetch side
    typedef logic [31:0] addr_t;

    // register number, rs/rt/rd fields
    typedef logic [4:0] reg_idx_t;

    // primary opcode field
    typedef logic [5:0] opcode_t;

endpackage

`default_nettype wire

// File: mips_branch_decode.sv
`default_nettype none

`include "mips_defs.svh"

module mips_branch_decode import mips_pkg::*; (
    input  word_t    instruction,
    input  addr_t    pc,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output reg_idx_t rs_addr,
    output reg_idx_t rt_addr,
    output logic     branch,
    output logic     jump,
    output logic     eq,
    output logic     lt,
    output word_t    immediate,
    output addr_t    target,
    output addr_t    jr_addr
);
    opcode_t    opcode;
    reg_idx_t   rt_code;
    logic [5:0] funct;
    addr_t      pc_plus4;
    logic       is_regimm_branch;
    logic       is_cmp_pair;

    assign opcode  = instruction[31:26];
    assign rt_code = instruction[20:16];
    assign funct   = instruction[5:0];

    assign rs_addr = instruction[25:21];
    assign rt_addr = instruction[20:16];

    // only the four regimm branches are handled here
    always_comb begin
        case (rt_code)
            `RT_BLTZ,
            `RT_BGEZ,
            `RT_BLTZAL,
            `RT_BGEZAL: is_regimm_branch = 1'b1;
            default:    is_regimm_branch = 1'b0;
        endcase
    end

    always_comb begin
        branch = 1'b0;
        jump   = 1'b0;
        case (opcode)
            `OP_BEQ,
            `OP_BNE,
            `OP_BLEZ,
            `OP_BGTZ: begin
                branch = 1'b1;
            end
            `OP_REGIMM: begin
                branch = is_regimm_branch;
            end
            `OP_J,
            `OP_JAL: begin
                jump = 1'b1;
            end
            `OP_SPECIAL: begin
                jump = (funct == `FN_JR) || (funct == `FN_JALR); // register jumps
            end
            default: begin
                branch = 1'b0;
                jump   = 1'b0;
            end
        endcase
    end

    // beq/bne compare two registers, the rest compare rs with zero
    assign is_cmp_pair = (opcode == `OP_BEQ) || (opcode == `OP_BNE);

    always_comb begin
        if (is_cmp_pair) begin
            eq = (rs_data == rt_data);
        end else begin
            eq = (rs_data == '0);
        end
        lt = rs_data[31]; // sign of rs
    end

    // word offset, already in bytes
    assign immediate = {{14{instruction[15]}}, instruction[15:0], 2'b00};

    assign pc_plus4 = pc + 32'd4;
    assign target   = {pc_plus4[31:28], instruction[25:0], 2'b00}; // 256MB region

    assign jr_addr = rs_data;

endmodule

`default_nettype wire

// File: mips_reg_file.sv
`default_nettype none

module mips_reg_file import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     clk_enable,
    input  reg_idx_t rs_addr,
    input  reg_idx_t rt_addr,
    input  logic     link_we,
    input  reg_idx_t link_addr,
    input  word_t    link_data,
    input  logic     wb_we,
    input  reg_idx_t wb_addr,
    input  word_t    wb_data,
    output word_t    rs_data,
    output word_t    rt_data
);
    word_t regs [32];
    logic  wb_blocked;

    // link wins a same-register collision
    assign wb_blocked = link_we && (link_addr == wb_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable) begin
            if (wb_we && (wb_addr != '0) && !wb_blocked) begin
                regs[wb_addr] <= wb_data;
            end
            if (link_we && (link_addr != '0)) begin
                regs[link_addr] <= link_data;
            end
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr]; // $zero
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: mips_pc_update.sv
`default_nettype none

`include "mips_defs.svh"

module mips_pc_update import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     clk_enable,
    input  logic     branch,
    input  logic     jump,
    input  logic     eq,
    input  logic     lt,
    input  word_t    instruction,
    input  word_t    immediate,
    input  addr_t    target,
    input  addr_t    jr_addr,
    output addr_t    pc,
    output logic     link_we,
    output reg_idx_t link_addr,
    output word_t    link_data
);
    opcode_t    opcode;
    reg_idx_t   rt_code;
    reg_idx_t   rd_field;
    logic [5:0] funct;
    addr_t      pc_plus4;
    addr_t      branch_addr;
    addr_t      next_target;
    logic       in_delay;      // current instruction is a delay slot
    logic       redirect;      // jump to redirect_addr on next edge
    addr_t      redirect_addr;
    logic       transfer;
    logic       taken;
    logic       links;

    assign opcode   = instruction[31:26];
    assign rt_code  = instruction[20:16];
    assign rd_field = instruction[15:11];
    assign funct    = instruction[5:0];

    assign pc_plus4    = pc + 32'd4;
    assign branch_addr = pc_plus4 + immediate;

    // branches in the delay slot fall through as ordinary instructions
    assign transfer = (branch || jump) && !in_delay;

    always_comb begin
        taken       = 1'b0;
        links       = 1'b0;
        next_target = branch_addr;
        if (jump) begin
            taken = 1'b1;
            case (opcode)
                `OP_J: begin
                    next_target = target;
                end
                `OP_JAL: begin
                    next_target = target;
                    links       = 1'b1;
                end
                default: begin
                    next_target = jr_addr; // jr, jalr
                    links       = (funct == `FN_JALR);
                end
            endcase
        end else if (branch) begin
            case (opcode)
                `OP_BEQ:  taken = eq;
                `OP_BNE:  taken = !eq;
                `OP_BLEZ: taken = eq || lt;
                `OP_BGTZ: taken = !eq && !lt;
                `OP_REGIMM: begin
                    case (rt_code)
                        `RT_BLTZ,
                        `RT_BLTZAL: taken = lt;
                        default:    taken = !lt; // bgez, bgezal
                    endcase
                    links = rt_code[4]; // the al forms
                end
                default: taken = 1'b0;
            endcase
        end
    end

    assign link_we   = clk_enable && transfer && links && taken;
    assign link_addr = (jump && (opcode == `OP_SPECIAL)) ? rd_field : `LINK_REG;
    assign link_data = pc + 32'd8; // return past the delay slot

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `MIPS_RESET_VECTOR;
            in_delay <= 1'b0;
            redirect <= 1'b0;
        end else if (clk_enable) begin
            pc       <= redirect ? redirect_addr : pc_plus4;
            in_delay <= transfer;
            redirect <= transfer && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable && transfer) begin
            redirect_addr <= next_target;
        end
    end

endmodule

`default_nettype wire

// File: mips_branch_unit.sv
`default_nettype none

module mips_branch_unit import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     clk_enable,
    input  word_t    instruction,
    input  logic     wb_we,
    input  reg_idx_t wb_addr,
    input  word_t    wb_data,
    output addr_t    pc,
    output word_t    rt_data
);
    reg_idx_t rs_addr;
    reg_idx_t rt_addr;
    word_t    rs_data;
    logic     branch;
    logic     jump;
    logic     eq;
    logic     lt;
    word_t    immediate;
    addr_t    target;
    addr_t    jr_addr;
    logic     link_we;
    reg_idx_t link_addr;
    word_t    link_data;

    mips_branch_decode decode_i (
        .instruction (instruction),
        .pc          (pc),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .branch      (branch),
        .jump        (jump),
        .eq          (eq),
        .lt          (lt),
        .immediate   (immediate),
        .target      (target),
        .jr_addr     (jr_addr)
    );

    mips_reg_file reg_file_i (
        .clk         (clk),
        .reset       (reset),
        .clk_enable  (clk_enable),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .link_we     (link_we),
        .link_addr   (link_addr),
        .link_data   (link_data),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data)
    );

    mips_pc_update pc_update_i (
        .clk         (clk),
        .reset       (reset),
        .clk_enable  (clk_enable),
        .branch      (branch),
        .jump        (jump),
        .eq          (eq),
        .lt          (lt),
        .instruction (instruction),
        .immediate   (immediate),
        .target      (target),
        .jr_addr     (jr_addr),
        .pc          (pc),
        .link_we     (link_we),
        .link_addr   (link_addr),
        .link_data   (link_data)
    );

endmodule

`default_nettype wire

// File: mips_branch_checker.sv
`default_nettype none

module mips_branch_checker import mips_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  clk_enable,
    input logic  branch,
    input logic  jump,
    input logic  link_we,
    input addr_t pc
);
    logic in_slot; // current instruction sits in a delay slot

    always_ff @(posedge clk) begin
        if (reset) begin
            in_slot <= 1'b0;
        end else if (clk_enable) begin
            in_slot <= (branch || jump) && !in_slot;
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc %08h is not word aligned", pc);

    link_needs_enable: assert property (@(posedge clk) disable iff (reset)
        link_we |-> (clk_enable && (branch || jump) && !in_slot))
        else $error("link write outside an enabled control transfer");

    delay_slot_next: assert property (@(posedge clk) disable iff (reset)
        (clk_enable && (branch || jump) && !in_slot) |=> (pc == $past(pc) + 32'd4))
        else $error("pc after a branch is not the delay slot address");

    pc_holds: assert property (@(posedge clk) disable iff (reset)
        !clk_enable |=> (pc == $past(pc)))
        else $error("pc changed during a stalled cycle");

endmodule

bind mips_branch_unit mips_branch_checker checker_i (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .branch     (branch),
    .jump       (jump),
    .link_we    (link_we),
    .pc         (pc)
);

`default_nettype wire

// File: tb_mips_branch_unit.sv
`default_nettype none

`include "mips_defs.svh"

module tb_mips_branch_unit import mips_pkg::*; ();

    logic     clk;
    logic     reset;
    logic     clk_enable;
    word_t    instruction;
    logic     wb_we;
    reg_idx_t wb_addr;
    word_t    wb_data;
    addr_t    pc;
    word_t    rt_data;

    byte   vec_kind   [$];
    word_t vec_a      [$];
    word_t vec_d      [$];
    addr_t vec_pc     [$];
    string test_name  [$];
    int    test_start [$]; // first vector of each test

    int   test_errors;
    int   pass_count;
    int   fail_count;
    logic vectors_loaded;

    mips_branch_unit dut_i (
        .clk         (clk),
        .reset       (reset),
        .clk_enable  (clk_enable),
        .instruction (instruction),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .pc          (pc),
        .rt_data     (rt_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic load_vectors;
        int    fd;
        int    code;
        int    ch;
        logic  done;
        string tok;
        word_t a;
        word_t d;
        word_t p;
        fd = $fopen("mips_branch_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open mips_branch_vectors.txt");
            return;
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok[0] == "#") begin
                ch = $fgetc(fd); // skip the rest of a comment line
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (tok == "T") begin
                code = $fscanf(fd, "%s", tok);
                test_name.push_back(tok);
                test_start.push_back(vec_kind.size());
            end else begin
                code = $fscanf(fd, "%h %h %h", a, d, p);
                vec_kind.push_back(tok[0]);
                vec_a.push_back(a);
                vec_d.push_back(d);
                vec_pc.push_back(p);
            end
        end
        $fclose(fd);
    endtask

    // drive one vector line, then check pc after the edge
    task automatic apply_vector(input int idx);
        byte   kind;
        word_t a;
        word_t d;
        addr_t p;
        kind        = vec_kind[idx];
        a           = vec_a[idx];
        d           = vec_d[idx];
        p           = vec_pc[idx];
        clk_enable  = 1'b1;
        instruction = '0;
        wb_we       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        case (kind)
            "W": begin
                wb_we   = 1'b1;
                wb_addr = a[4:0];
                wb_data = d;
            end
            "I": instruction = a;
            "S": begin
                instruction = a;
                clk_enable  = 1'b0; // no state may change
                wb_we       = 1'b1; // stalled write to r31 must be dropped
                wb_addr     = `LINK_REG;
                wb_data     = d;
            end
            "R": begin
                instruction = a;
                clk_enable  = 1'b0;
            end
            "C": begin
                instruction = a;
                wb_we       = 1'b1; // collides with the link write
                wb_addr     = `LINK_REG;
                wb_data     = d;
            end
            default: begin
                $display("vector %0d has an unknown kind letter %c", idx, kind);
                test_errors++;
            end
        endcase
        if (kind == "R") begin
            #3;
            if (rt_data !== d) begin
                $display("MISMATCH at %0t: rt_data expected %08h, got %08h (vector %0d)",
                         $time, d, rt_data, idx);
                test_errors++;
            end
        end
        @(posedge clk);
        #1;
        if (pc !== p) begin
            $display("MISMATCH at %0t: pc expected %08h, got %08h (vector %0d)",
                     $time, p, pc, idx);
            test_errors++;
        end
    endtask

    task automatic run_tests;
        int last;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        if (pc !== `MIPS_RESET_VECTOR) begin
            $display("MISMATCH at %0t: pc expected %08h, got %08h",
                     $time, `MIPS_RESET_VECTOR, pc);
            test_errors++;
        end
        for (int t = 0; t < test_name.size(); t++) begin
            last = (t + 1 < test_name.size()) ? test_start[t + 1] : vec_kind.size();
            for (int i = test_start[t]; i < last; i++) begin
                apply_vector(i);
            end
            if (test_errors == 0) begin
                pass_count++;
                $display("test %0d %s: ok", t + 1, test_name[t]);
            end else begin
                fail_count++;
                $display("test %0d %s: %0d errors", t + 1, test_name[t], test_errors);
            end
            test_errors = 0;
        end
    endtask

    initial begin
        reset          = 1'b1;
        clk_enable     = 1'b0;
        instruction    = '0;
        wb_we          = 1'b0;
        wb_addr        = '0;
        wb_data        = '0;
        test_errors    = 0;
        pass_count     = 0;
        fail_count     = 0;
        vectors_loaded = 1'b0;
        load_vectors();
        vectors_loaded = 1'b1;
        if (vec_kind.size() == 0 || test_name.size() == 0) begin
            $display("no vectors could be read from mips_branch_vectors.txt");
            fail_count = 1;
        end else begin
            run_tests();
        end
        $display("%0d tests run: %0d ok, %0d with errors",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog, sized from the vector count
    initial begin
        int limit;
        wait (vectors_loaded === 1'b1);
        limit = vec_kind.size() * 20 + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mips_branch_vectors.txt
# T <name> starts a test; other lines: kind  instr/addr  data  expected pc after the edge
# W write reg, I issue, S stalled issue, R check reg via rt (stalled), C issue with wb to r31
T reset_and_fetch
I 00000000 00000000 BFC00004
I 00000000 00000000 BFC00008
I 00000000 00000000 BFC0000C
T compare_branches
W 00000001 00000005 BFC00010
W 00000002 00000005 BFC00014
W 00000003 FFFFFFF0 BFC00018
I 10220003 00000000 BFC0001C
I 00000000 00000000 BFC00028
I 14220003 00000000 BFC0002C
I 00000000 00000000 BFC00030
I 1423FFFE 00000000 BFC00034
I 00000000 00000000 BFC0002C
I 1C200004 00000000 BFC00030
I 00000000 00000000 BFC00040
I 18600002 00000000 BFC00044
I 00000000 00000000 BFC0004C
I 1C000002 00000000 BFC00050
I 00000000 00000000 BFC00054
T regimm_branches
I 04600002 00000000 BFC00058
I 00000000 00000000 BFC00060
I 04610002 00000000 BFC00064
I 00000000 00000000 BFC00068
I 04010002 00000000 BFC0006C
I 00000000 00000000 BFC00074
I 04300002 00000000 BFC00078
I 00000000 00000000 BFC0007C
R 001F0000 00000000 BFC0007C
I 04310003 00000000 BFC00080
I 00000000 00000000 BFC0008C
R 001F0000 BFC00084 BFC0008C
I 04700001 00000000 BFC00090
I 00000000 00000000 BFC00094
R 001F0000 BFC00094 BFC00094
T jumps
I 0BF00040 00000000 BFC00098
I 00000000 00000000 BFC00100
I 0FF00080 00000000 BFC00104
I 00000000 00000000 BFC00200
R 001F0000 BFC00108 BFC00200
W 00000005 BFC00300 BFC00204
I 00A00008 00000000 BFC00208
I 00000000 00000000 BFC00300
I 00A03809 00000000 BFC00304
I 00000000 00000000 BFC00300
R 00070000 BFC00308 BFC00300
T stall_mid_branch
S 10220003 00000000 BFC00300
I 10220003 00000000 BFC00304
S 00000000 00000000 BFC00304
S 00000000 00000000 BFC00304
I 00000000 00000000 BFC00310
R 001F0000 BFC00108 BFC00310
T zero_reg_and_priority
W 00000000 12345678 BFC00314
R 00000000 00000000 BFC00314
C 0FF00100 DEADBEEF BFC00318
I 00000000 00000000 BFC00400
R 001F0000 BFC0031C BFC00400
T branch_in_delay_slot
I 0BF00140 00000000 BFC00404
I 04110008 00000000 BFC00500
I 00000000 00000000 BFC00504
R 001F0000 BFC0031C BFC00504

// File: sim.f
+incdir+.
mips_pkg.sv
mips_branch_decode.sv
mips_reg_file.sv
mips_pc_update.sv
mips_branch_unit.sv
mips_branch_checker.sv
tb_mips_branch_unit.sv
